/* src/dmg_clk_pkg.sv */
package dmg_clk_pkg;

	// Low two bits of the CPU address within 0xFF04 to 0xFF07.
	typedef enum logic [1:0] {
		REG_DIV  = 2'd0,
		REG_TIMA = 2'd1,
		REG_TMA  = 2'd2,
		REG_TAC  = 2'd3
	} reg_addr_e;

	// TAC bits 1 to 0 pick the divider tap that clocks TIMA.
	typedef enum logic [1:0] {
		SEL_1024 = 2'd0, // 4096 Hz.
		SEL_16   = 2'd1, // 262144 Hz.
		SEL_64   = 2'd2, // 65536 Hz.
		SEL_256  = 2'd3  // 16384 Hz.
	} tac_sel_e;

	// Position of clkin within the four-cycle machine cycle.
	typedef enum logic [1:0] {
		PH_T1 = 2'd0,
		PH_T2 = 2'd1,
		PH_T3 = 2'd2,
		PH_T4 = 2'd3
	} phase_e;

	// Width of the free-running system counter.
	localparam int DIV_W = 16;

	// Bit 12 of the counter falls at 512 Hz and steps the frame sequencer.
	localparam int FRAME_TAP = 12;

	// Cycles TIMA reads zero after it wraps, before TMA is loaded.
	localparam int RELOAD_DELAY = 4;

endpackage

/* src/phase_reset_gen.sv */
`timescale 1ns/1ps

module phase_reset_gen #(
	parameter int RESET_HOLD = 16
) (
	input  logic                clkin,
	input  logic                rst_n,
	output logic                cpu_rst_n,
	output dmg_clk_pkg::phase_e phase,
	output logic                mcycle
);

	import dmg_clk_pkg::*;

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic              hold_last;

	// The phase counter runs freely once rst_n is high.
	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			phase  <= PH_T1;
			mcycle <= 1'b0;
		end else begin
			phase  <= phase_e'(phase + 2'd1);
			mcycle <= (phase == PH_T3); // Set on the same edge that enters PH_T4.
		end
	end

	assign hold_last = (hold_cnt == HOLD_W'(RESET_HOLD - 1));

	// The CPU stays in reset for RESET_HOLD clkin cycles after rst_n rises.
	// The counter stops once the release has happened.
	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt  <= '0;
			cpu_rst_n <= 1'b0;
		end else if (!cpu_rst_n) begin
			hold_cnt <= hold_cnt + 1'b1;
			if (hold_last)
				cpu_rst_n <= 1'b1;
		end
	end

endmodule

/* src/sys_divider.sv */
`timescale 1ns/1ps

module sys_divider (
	input  logic                          clkin,
	input  logic                          rst_n,
	input  logic                          div_clr,
	output logic [dmg_clk_pkg::DIV_W-1:0] sys_cnt
);

	import dmg_clk_pkg::*;

	logic [DIV_W-1:0] cnt_next;

	// Every timer and frame rate in the block is a tap of this counter.
	// A write to DIV zeroes the whole counter and not only the visible byte.
	assign cnt_next = div_clr ? '0 : sys_cnt + DIV_W'(1);

	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n)
			sys_cnt <= '0;
		else
			sys_cnt <= cnt_next;
	end

endmodule

/* src/timer_unit.sv */
`timescale 1ns/1ps

module timer_unit (
	input  logic                          clkin,
	input  logic                          rst_n,
	input  logic [dmg_clk_pkg::DIV_W-1:0] sys_cnt,
	input  logic [7:0]                    reg_wdata,
	input  logic                          tima_we,
	input  logic                          tma_we,
	input  logic                          tac_we,
	output logic [7:0]                    tima,
	output logic [7:0]                    tma,
	output logic [2:0]                    tac,
	output logic                          timer_irq
);

	import dmg_clk_pkg::*;

	localparam int DLY_W = $clog2(RELOAD_DELAY);

	typedef enum logic [1:0] {
		TMR_COUNT,
		TMR_OVF_WAIT,
		TMR_RELOAD
	} tmr_state_e;

	tmr_state_e       state;
	tac_sel_e         sel;
	logic             tap_bit;
	logic             tap_gated;
	logic             tap_d;
	logic             tick;
	logic [DLY_W-1:0] dly_cnt;

	assign sel = tac_sel_e'(tac[1:0]);

	always_comb begin
		case (sel)
			SEL_1024: tap_bit = sys_cnt[9];
			SEL_16:   tap_bit = sys_cnt[3];
			SEL_64:   tap_bit = sys_cnt[5];
			default:  tap_bit = sys_cnt[7];
		endcase
	end

	// The enable is ANDed in before the edge detector, as on the real chip.
	// Dropping the enable while the tap is high therefore counts once.
	assign tap_gated = tap_bit & tac[2];
	assign tick = tap_d & ~tap_gated;

	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			tap_d <= 1'b0;
			tma   <= 8'h00;
			tac   <= 3'b000;
		end else begin
			tap_d <= tap_gated;
			if (tma_we)
				tma <= reg_wdata;
			if (tac_we)
				tac <= reg_wdata[2:0];
		end
	end

	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			state     <= TMR_COUNT;
			tima      <= 8'h00;
			dly_cnt   <= '0;
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= 1'b0;
			case (state)
				TMR_COUNT: begin
					if (tima_we) begin
						tima <= reg_wdata; // A CPU write beats a tick on the same edge.
					end else if (tick) begin
						tima <= tima + 8'd1;
						if (tima == 8'hFF) begin
							state   <= TMR_OVF_WAIT;
							dly_cnt <= '0;
						end
					end
				end
				TMR_OVF_WAIT: begin
					if (tima_we) begin
						tima  <= reg_wdata;
						state <= TMR_COUNT;
					end else if (dly_cnt == DLY_W'(RELOAD_DELAY - 2)) begin
						state <= TMR_RELOAD;
					end else begin
						dly_cnt <= dly_cnt + 1'b1;
					end
				end
				TMR_RELOAD: begin
					state <= TMR_COUNT;
					if (tima_we) begin
						tima <= reg_wdata; // Cancels the reload and the interrupt.
					end else begin
						tima      <= tma_we ? reg_wdata : tma;
						timer_irq <= 1'b1;
					end
				end
				default: state <= TMR_COUNT;
			endcase
		end
	end

endmodule

/* src/apu_frame_clk.sv */
`timescale 1ns/1ps

module apu_frame_clk (
	input  logic                          clkin,
	input  logic                          rst_n,
	input  logic [dmg_clk_pkg::DIV_W-1:0] sys_cnt,
	output logic [2:0]                    frame_step,
	output logic                          clk_256hz,
	output logic                          clk_128hz,
	output logic                          clk_64hz
);

	import dmg_clk_pkg::*;

	logic       tap_d;
	logic       step_en;
	logic [2:0] step_next;

	// The tap falls at 512 Hz, which is the rate of the eight-step sequencer.
	assign step_en   = tap_d & ~sys_cnt[FRAME_TAP];
	assign step_next = frame_step + 3'd1;

	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			tap_d      <= 1'b0;
			frame_step <= 3'd0;
			clk_256hz  <= 1'b0;
			clk_128hz  <= 1'b0;
			clk_64hz   <= 1'b0;
		end else begin
			tap_d     <= sys_cnt[FRAME_TAP];
			clk_256hz <= 1'b0;
			clk_128hz <= 1'b0;
			clk_64hz  <= 1'b0;
			if (step_en) begin
				frame_step <= step_next;
				clk_256hz  <= ~step_next[0]; // Length counters.
				clk_128hz  <= (step_next == 3'd2) || (step_next == 3'd6); // Sweep.
				clk_64hz   <= (step_next == 3'd7); // Envelopes.
			end
		end
	end

endmodule

/* src/timer_regs_port.sv */
`timescale 1ns/1ps

module timer_regs_port (
	input  logic                          clkin,
	input  logic                          rst_n,
	input  dmg_clk_pkg::reg_addr_e        addr,
	input  logic                          wr,
	input  logic                          rd,
	input  logic [7:0]                    wdata,
	input  logic [dmg_clk_pkg::DIV_W-1:0] sys_cnt,
	input  logic [7:0]                    tima,
	input  logic [7:0]                    tma,
	input  logic [2:0]                    tac,
	output logic                          div_clr,
	output logic                          tima_we,
	output logic                          tma_we,
	output logic                          tac_we,
	output logic [7:0]                    reg_wdata,
	output logic                          [7:0] rdata
);

	import dmg_clk_pkg::*;

	logic [7:0] rd_mux;

	// Writes land on the edge where wr is high, so the strobes stay combinational.
	assign div_clr   = wr && (addr == REG_DIV);
	assign tima_we   = wr && (addr == REG_TIMA);
	assign tma_we    = wr && (addr == REG_TMA);
	assign tac_we    = wr && (addr == REG_TAC);
	assign reg_wdata = wdata;

	always_comb begin
		case (addr)
			REG_DIV:  rd_mux = sys_cnt[DIV_W-1 -: 8]; // DIV is the upper byte of the counter.
			REG_TIMA: rd_mux = tima;
			REG_TMA:  rd_mux = tma;
			default:  rd_mux = {5'b11111, tac}; // Unused TAC bits read high.
		endcase
	end

	// Read data is captured on rd and held until the next read.
	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n)
			rdata <= 8'h00;
		else if (rd)
			rdata <= rd_mux;
	end

endmodule

/* src/clocks_reset_top.sv */
`timescale 1ns/1ps

module clocks_reset_top #(
	parameter int RESET_HOLD = 16
) (
	input  logic                   clkin,
	input  logic                   rst_n,
	input  dmg_clk_pkg::reg_addr_e addr,
	input  logic                   wr,
	input  logic                   rd,
	input  logic [7:0]             wdata,
	output logic [7:0]             rdata,
	output logic                   timer_irq,
	output logic                   cpu_rst_n,
	output logic                   mcycle,
	output dmg_clk_pkg::phase_e    phase,
	output logic [2:0]             frame_step,
	output logic                   clk_256hz,
	output logic                   clk_128hz,
	output logic                   clk_64hz
);

	import dmg_clk_pkg::*;

	logic             div_clr;
	logic             tima_we;
	logic             tma_we;
	logic             tac_we;
	logic [7:0]       reg_wdata;
	logic [DIV_W-1:0] sys_cnt;
	logic [7:0]       tima;
	logic [7:0]       tma;
	logic [2:0]       tac;

	phase_reset_gen #(
		.RESET_HOLD (RESET_HOLD)
	) u_phase_reset_gen (
		.clkin     (clkin),
		.rst_n     (rst_n),
		.cpu_rst_n (cpu_rst_n),
		.phase     (phase),
		.mcycle    (mcycle)
	);

	timer_regs_port u_timer_regs_port (
		.clkin     (clkin),
		.rst_n     (rst_n),
		.addr      (addr),
		.wr        (wr),
		.rd        (rd),
		.wdata     (wdata),
		.sys_cnt   (sys_cnt),
		.tima      (tima),
		.tma       (tma),
		.tac       (tac),
		.div_clr   (div_clr),
		.tima_we   (tima_we),
		.tma_we    (tma_we),
		.tac_we    (tac_we),
		.reg_wdata (reg_wdata),
		.rdata     (rdata)
	);

	sys_divider u_sys_divider (
		.clkin   (clkin),
		.rst_n   (rst_n),
		.div_clr (div_clr),
		.sys_cnt (sys_cnt)
	);

	timer_unit u_timer_unit (
		.clkin     (clkin),
		.rst_n     (rst_n),
		.sys_cnt   (sys_cnt),
		.reg_wdata (reg_wdata),
		.tima_we   (tima_we),
		.tma_we    (tma_we),
		.tac_we    (tac_we),
		.tima      (tima),
		.tma       (tma),
		.tac       (tac),
		.timer_irq (timer_irq)
	);

	apu_frame_clk u_apu_frame_clk (
		.clkin      (clkin),
		.rst_n      (rst_n),
		.sys_cnt    (sys_cnt),
		.frame_step (frame_step),
		.clk_256hz  (clk_256hz),
		.clk_128hz  (clk_128hz),
		.clk_64hz   (clk_64hz)
	);

endmodule

/* testbench/clocks_reset_sva.sv */
`timescale 1ns/1ps

module clocks_reset_sva (
	input logic                clkin,
	input logic                rst_n,
	input logic                cpu_rst_n,
	input logic                mcycle,
	input dmg_clk_pkg::phase_e phase,
	input logic                timer_irq,
	input logic [2:0]          frame_step
);

	import dmg_clk_pkg::*;

	// The machine-cycle strobe marks the last T-phase only.
	mcycle_on_t4: assert property (@(posedge clkin) disable iff (!rst_n)
		mcycle == (phase == PH_T4))
		else $error("mcycle and phase disagree");

	irq_one_cycle: assert property (@(posedge clkin) disable iff (!rst_n)
		timer_irq |=> !timer_irq)
		else $error("timer_irq longer than one cycle");

	cpu_held_in_reset: assert property (@(posedge clkin)
		!rst_n |-> !cpu_rst_n)
		else $error("cpu_rst_n high while rst_n low");

	// The sequencer only ever moves forward by one step.
	frame_step_by_one: assert property (@(posedge clkin) disable iff (!rst_n)
		(frame_step != $past(frame_step)) |-> (frame_step == 3'($past(frame_step) + 3'd1)))
		else $error("frame_step jumped");

endmodule

bind clocks_reset_top clocks_reset_sva u_sva (.*);

/* testbench/tb_clocks_reset.sv */
`timescale 1ns/1ps

module tb_clocks_reset;

	import dmg_clk_pkg::*;

	localparam int HOLD = 16;
	localparam int TIMEOUT = 5000;

	typedef enum {OP_WR, OP_RD, OP_RD2, OP_WAIT, OP_IRQ, OP_FRAME} op_e;

	typedef struct {
		op_e       op;
		reg_addr_e addr;
		int        data;
		int        exp;
		int        test;
	} entry_t;

	logic       clkin, rst_n, wr, rd;
	reg_addr_e  addr;
	logic [7:0] wdata, rdata;
	logic       timer_irq, cpu_rst_n, mcycle;
	phase_e     phase;
	logic [2:0] frame_step;
	logic       clk_256hz, clk_128hz, clk_64hz;

	entry_t tbl[$];
	int     seed = 32'h7b0c;
	int     errors = 0;
	int     tests_ok = 0;
	int     tests_bad = 0;
	bit     timed_out = 1'b0;

	clocks_reset_top #(.RESET_HOLD(HOLD)) dut (.*);

	initial begin
		clkin = 1'b0;
		forever #5 clkin = ~clkin;
	end

	task automatic check(input int actual, input int expected, input string msg);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, msg, actual, expected);
			errors++;
		end
	endtask

	task automatic add(input op_e op, input reg_addr_e a, input int d, input int e, input int t);
		entry_t en;
		en.op = op;
		en.addr = a;
		en.data = d;
		en.exp = e;
		en.test = t;
		tbl.push_back(en);
	endtask

	task automatic note_timeout(input string what);
		$display("Timeout while waiting for %s, the run stops here.", what);
		timed_out = 1'b1;
	endtask

	task automatic bus_write(input reg_addr_e a, input logic [7:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		@(posedge clkin);
		#1;
		wr = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_e a, output logic [7:0] v);
		addr = a;
		rd = 1'b1;
		@(posedge clkin);
		#1;
		rd = 1'b0;
		v = rdata; // Registered on the edge where rd was high.
	endtask

	task automatic report_test(input int t, input int err_start);
		if (errors == err_start && !timed_out) begin
			$display("Test %0d passed", t);
			tests_ok++;
		end else begin
			$display("Test %0d failed with %0d errors", t, errors - err_start);
			tests_bad++;
		end
	endtask

	// Timer tap bits 9, 3, 5 and 7 fall once every 2^(bit+1) cycles.
	function automatic int tap_period(input tac_sel_e s);
		case (s)
			SEL_1024: return 1024;
			SEL_16:   return 16;
			SEL_64:   return 64;
			default:  return 256;
		endcase
	endfunction

	task automatic build_table();
		tac_sel_e sels[5] = '{SEL_16, SEL_64, SEL_256, SEL_1024, SEL_16};
		int start;
		int r;
		for (int k = 1; k <= 3; k++) begin
			add(OP_WR, REG_DIV, 0, 0, 2);
			add(OP_WAIT, REG_DIV, 256 * k, 0, 2);
			add(OP_RD, REG_DIV, 0, k, 2);
		end
		add(OP_WR, REG_DIV, 0, 0, 2);
		add(OP_RD, REG_DIV, 0, 0, 2);
		foreach (sels[i]) begin
			start = $random(seed) & 8'h7f;
			add(OP_WR, REG_TAC, 4 | int'(sels[i]), 0, 3);
			add(OP_RD, REG_TAC, 0, 8'hf8 | 4 | int'(sels[i]), 3);
			add(OP_WR, REG_DIV, 0, 0, 3);
			add(OP_WR, REG_TIMA, start, 0, 3);
			add(OP_WAIT, REG_DIV, tap_period(sels[i]) * 3, 0, 3);
			add(OP_RD2, REG_TIMA, 0, start + 3, 3);
		end
		r = $random(seed) & 8'hff;
		add(OP_WR, REG_TAC, 4 | int'(SEL_16), 0, 4);
		add(OP_WR, REG_TMA, r, 0, 4);
		add(OP_WR, REG_DIV, 0, 0, 4);
		add(OP_WR, REG_TIMA, 8'hff, 0, 4);
		// One tap period to the wrap, then the zero window before the reload.
		add(OP_IRQ, REG_DIV, 0, tap_period(SEL_16) + RELOAD_DELAY, 4);
		add(OP_RD, REG_TIMA, 0, r, 4);
		add(OP_WR, REG_DIV, 0, 0, 5);
		add(OP_FRAME, REG_DIV, 8 * (1 << (FRAME_TAP + 1)), (4 << 16) | (2 << 8) | 1, 5);
	endtask

	task automatic check_reset();
		int cnt;
		int pulses;
		cnt = 0;
		while (!cpu_rst_n && !timed_out) begin
			@(posedge clkin);
			#1;
			cnt++;
			if (cnt > TIMEOUT)
				note_timeout("cpu_rst_n to rise");
		end
		if (timed_out)
			return;
		check(cnt, HOLD, "cycles from rst_n to cpu_rst_n");
		pulses = 0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clkin);
			#1;
			if (mcycle) begin
				pulses++;
				check(phase, PH_T4, "phase during mcycle");
			end
		end
		check(pulses, 4, "mcycle pulses in 16 cycles");
	endtask

	task automatic run_entry(input entry_t en);
		logic [7:0] v;
		logic [2:0] step0;
		int cnt;
		int c256, c128, c64;
		case (en.op)
			OP_WR:   bus_write(en.addr, en.data[7:0]);
			OP_RD: begin
				bus_read(en.addr, v);
				check(v, en.exp, "register read");
			end
			OP_RD2: begin
				for (int i = 0; i < 2; i++) begin
					bus_read(en.addr, v);
					if (v !== en.exp && v !== en.exp + 1)
						check(v, en.exp, "timer count outside tolerance");
				end
			end
			OP_WAIT: begin
				for (int i = 0; i < en.data; i++)
					@(posedge clkin);
				#1;
			end
			OP_IRQ: begin
				cnt = 0;
				do begin
					@(posedge clkin);
					#1;
					cnt++;
					if (cnt > TIMEOUT)
						note_timeout("timer_irq");
				end while (!timer_irq && !timed_out);
				if (!timed_out)
					check(cnt, en.exp, "cycles from TIMA write to timer_irq");
			end
			default: begin
				c256 = 0;
				c128 = 0;
				c64 = 0;
				@(posedge clkin); // First step lands 8193 cycles after the clear.
				#1;
				step0 = frame_step;
				for (int i = 0; i < en.data; i++) begin
					@(posedge clkin);
					#1;
					c256 += clk_256hz;
					c128 += clk_128hz;
					c64 += clk_64hz;
				end
				check((c256 << 16) | (c128 << 8) | c64, en.exp, "frame strobe counts packed");
				check(frame_step, step0, "frame_step after eight steps");
			end
		endcase
	endtask

	initial begin
		int cur;
		int err_start;
		rst_n = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		addr = REG_DIV;
		wdata = 8'h00;
		build_table();
		repeat (8) @(posedge clkin);
		#1;
		rst_n = 1'b1;
		err_start = errors;
		check_reset();
		report_test(1, err_start);
		if (!timed_out) begin
			cur = tbl[0].test;
			err_start = errors;
			foreach (tbl[i]) begin
				if (tbl[i].test != cur) begin
					report_test(cur, err_start);
					cur = tbl[i].test;
					err_start = errors;
				end
				run_entry(tbl[i]);
				if (timed_out)
					break;
			end
			report_test(cur, err_start);
		end
		$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
		if (errors == 0 && !timed_out)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* verilog.f */
src/dmg_clk_pkg.sv
src/phase_reset_gen.sv
src/sys_divider.sv
src/timer_unit.sv
src/apu_frame_clk.sv
src/timer_regs_port.sv
src/clocks_reset_top.sv
testbench/clocks_reset_sva.sv
testbench/tb_clocks_reset.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
TOP       ?= tb_clocks_reset
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
